//--- src/tcb_lite_macros.svh
`ifndef TCB_LITE_MACROS_SVH
`define TCB_LITE_MACROS_SVH

// bus widths
`define TCB_ADR_W 32
`define TCB_DAT_W 32
`define TCB_BEN_W 4

// memory holds 256 words, addressed by 10 byte-address bits
`define MEM_ADR_W 10

// address map, region sizes given as the number of offset bits
`define MEM_BASE      32'h0000_0000
`define MEM_REGION_W  12
`define GPIO_BASE     32'h0001_0000
`define GPIO_REGION_W 8

// pin count
`define GPIO_W 16

`endif

//--- src/tcb_lite_pkg.sv
package tcb_lite_pkg;

    `include "tcb_lite_macros.svh"

    ////////////////////////////////////////
    // bus level types
    ////////////////////////////////////////

    // one enable bit per data byte
    typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;

    // target of a single transfer
    typedef enum logic [1:0] {
        SEL_MEM  = 2'd0,
        SEL_GPIO = 2'd1,
        // anything unmapped lands here
        SEL_ERR  = 2'd2
    } tcb_sel_t;

endpackage : tcb_lite_pkg

//--- src/gpio_pkg.sv
package gpio_pkg;

    `include "tcb_lite_macros.svh"

    // register offsets inside the gpio region
    typedef enum logic [`GPIO_REGION_W-1:0] {
        REG_OUT     = 8'h00,
        REG_SETCLR  = 8'h04,
        REG_OE      = 8'h08,
        REG_IN      = 8'h0C,
        REG_IRQ_ENA = 8'h10,
        REG_IRQ_PND = 8'h14
    } gpio_reg_e;

    // set mask in the upper half, clear mask in the lower half
    typedef struct packed {
        logic [`GPIO_W-1:0] set;
        logic [`GPIO_W-1:0] clr;
    } gpio_setclr_t;

    // one write word, seen either as a plain value or as set/clear masks
    typedef union packed {
        logic [`TCB_DAT_W-1:0] val;
        gpio_setclr_t          setclr;
    } gpio_wdt_u;

endpackage : gpio_pkg

//--- src/tcb_lite_dec.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module tcb_lite_dec (
    input  logic                  tcb,
    input  logic                  reset,
    // manager side
    input  logic                  vld,
    input  logic [`TCB_ADR_W-1:0] adr,
    output logic [`TCB_DAT_W-1:0] rdt,
    output logic                  err,
    // subordinate strobes
    output logic                  mem_vld,
    output logic                  gpio_vld,
    output logic                  err_vld,
    // subordinate responses
    input  logic [`TCB_DAT_W-1:0] mem_rdt,
    input  logic [`TCB_DAT_W-1:0] gpio_rdt,
    input  logic [`TCB_DAT_W-1:0] sub_err_rdt,
    input  logic                  sub_err_err
);

    import tcb_lite_pkg::*;

    // current selection and the one from the previous cycle
    tcb_sel_t sel;
    tcb_sel_t sel_dly;
    // previous cycle carried a transfer
    logic     trn_dly;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    // compare only the bits above each region's offset
    always_comb begin
        if ((adr >> `MEM_REGION_W) == (`MEM_BASE >> `MEM_REGION_W)) begin
            sel = SEL_MEM;
        end else if ((adr >> `GPIO_REGION_W) == (`GPIO_BASE >> `GPIO_REGION_W)) begin
            sel = SEL_GPIO;
        end else begin
            sel = SEL_ERR;
        end
    end

    // one strobe per transfer
    assign mem_vld  = vld && (sel == SEL_MEM);
    assign gpio_vld = vld && (sel == SEL_GPIO);
    assign err_vld  = vld && (sel == SEL_ERR);

    ////////////////////////////////////////
    // response path
    ////////////////////////////////////////

    // transfer flag follows vld by one cycle
    always_ff @(posedge tcb) begin
        if (reset) begin
            trn_dly <= 1'b0;
        end else begin
            trn_dly <= vld;
        end
    end

    // selection only matters when trn_dly is set
    always_ff @(posedge tcb) begin
        if (vld) begin
            sel_dly <= sel;
        end
    end

    // idle cycles return zero
    always_comb begin
        rdt = '0;
        err = 1'b0;
        if (trn_dly) begin
            case (sel_dly)
                SEL_MEM:  rdt = mem_rdt;
                SEL_GPIO: rdt = gpio_rdt;
                default: begin
                    rdt = sub_err_rdt;
                    err = sub_err_err;
                end
            endcase
        end
    end

    // every transfer goes to exactly one subordinate
    a_one_strobe : assert property (@(posedge tcb) disable iff (reset)
        vld |-> $onehot({mem_vld, gpio_vld, err_vld}));

endmodule : tcb_lite_dec

//--- src/tcb_lite_sub_mem.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module tcb_lite_sub_mem (
    input  logic                  tcb,
    input  logic                  mem_vld,
    input  logic                  wen,
    input  logic [`TCB_ADR_W-1:0] adr,
    input  tcb_lite_pkg::tcb_ben_t ben,
    input  logic [`TCB_DAT_W-1:0] wdt,
    output logic [`TCB_DAT_W-1:0] rdt
);

    // byte offset bits inside one word
    localparam int unsigned BYT_W = $clog2(`TCB_BEN_W);
    // word count from the byte address width
    localparam int unsigned MEM_WORDS = 1 << (`MEM_ADR_W - BYT_W);

    logic [`TCB_DAT_W-1:0]        mem [0:MEM_WORDS-1];
    // word index, upper address bits alias
    logic [`MEM_ADR_W-BYT_W-1:0] idx;

    assign idx = adr[`MEM_ADR_W-1:BYT_W];

    ////////////////////////////////////////
    // write and read ports
    ////////////////////////////////////////

    // only enabled bytes are written
    always_ff @(posedge tcb) begin
        if (mem_vld && wen) begin
            for (int b = 0; b < `TCB_BEN_W; b++) begin
                if (ben[b]) begin
                    mem[idx][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

    // read data registered, ben ignored on reads
    always_ff @(posedge tcb) begin
        if (mem_vld && !wen) begin
            rdt <= mem[idx];
        end
    end

    // writes must touch at least one byte
    a_wr_ben : assert property (@(posedge tcb)
        (mem_vld && wen) |-> (ben != '0));

endmodule : tcb_lite_sub_mem

//--- src/tcb_lite_sub_err.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module tcb_lite_sub_err (
    input  logic                  tcb,
    input  logic                  reset,
    input  logic                  err_vld,
    input  logic [`TCB_ADR_W-1:0] adr,
    output logic [`TCB_DAT_W-1:0] rdt,
    output logic                  err,
    output logic                  bus_fault,
    output logic [`TCB_ADR_W-1:0] fault_adr
);

    // no data behind this subordinate
    assign rdt = '0;

    // error response and fault address capture
    always_ff @(posedge tcb) begin
        if (reset) begin
            err       <= 1'b0;
            fault_adr <= '0;
        end else begin
            err <= err_vld;
            if (err_vld) begin
                fault_adr <= adr;
            end
        end
    end

    // strobe lines up with the error response
    assign bus_fault = err;

    // a long strobe only comes from faults issued back to back
    a_fault_pulse : assert property (@(posedge tcb) disable iff (reset)
        (bus_fault && $past(bus_fault)) |-> ($past(err_vld) && $past(err_vld, 2)));

endmodule : tcb_lite_sub_err

//--- src/gpio_regs.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module gpio_regs (
    input  logic                  tcb,
    input  logic                  reset,
    // bus access
    input  logic                  gpio_vld,
    input  logic                  wen,
    input  logic [`TCB_ADR_W-1:0] adr,
    input  gpio_pkg::gpio_wdt_u   wdt,
    output logic [`TCB_DAT_W-1:0] rdt,
    // pin logic
    output logic [`GPIO_W-1:0]    out_val,
    output logic [`GPIO_W-1:0]    oe_val,
    output logic [`GPIO_W-1:0]    irq_ena,
    input  logic [`GPIO_W-1:0]    in_sync,
    input  logic [`GPIO_W-1:0]    rise_evt,
    output logic                  irq
);

    import gpio_pkg::*;

    gpio_reg_e             reg_sel;
    logic                  wr;
    logic [`GPIO_W-1:0]    irq_pnd;
    logic [`GPIO_W-1:0]    pnd_clr;
    logic [`TCB_DAT_W-1:0] rd_val;

    assign reg_sel = gpio_reg_e'(adr[`GPIO_REGION_W-1:0]);
    assign wr      = gpio_vld && wen;
    // written ones clear pending bits
    assign pnd_clr = (wr && reg_sel == REG_IRQ_PND) ? wdt.val[`GPIO_W-1:0] : '0;

    ////////////////////////////////////////
    // register writes
    ////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (reset) begin
            out_val <= '0;
            oe_val  <= '0;
            irq_ena <= '0;
            irq_pnd <= '0;
            irq     <= 1'b0;
        end else begin
            if (wr) begin
                case (reg_sel)
                    REG_OUT:     out_val <= wdt.val[`GPIO_W-1:0];
                    // set applied last, so it wins over clear
                    REG_SETCLR:  out_val <= (out_val & ~wdt.setclr.clr) | wdt.setclr.set;
                    REG_OE:      oe_val  <= wdt.val[`GPIO_W-1:0];
                    REG_IRQ_ENA: irq_ena <= wdt.val[`GPIO_W-1:0];
                    default: ;
                endcase
            end
            // new event beats a clear in the same cycle
            irq_pnd <= (irq_pnd & ~pnd_clr) | rise_evt;
            irq     <= |(irq_pnd & irq_ena);
        end
    end

    ////////////////////////////////////////
    // register reads
    ////////////////////////////////////////

    // setclr and unmapped offsets read zero
    always_comb begin
        rd_val = '0;
        case (reg_sel)
            REG_OUT:     rd_val[`GPIO_W-1:0] = out_val;
            REG_OE:      rd_val[`GPIO_W-1:0] = oe_val;
            REG_IN:      rd_val[`GPIO_W-1:0] = in_sync;
            REG_IRQ_ENA: rd_val[`GPIO_W-1:0] = irq_ena;
            REG_IRQ_PND: rd_val[`GPIO_W-1:0] = irq_pnd;
            default: ;
        endcase
    end

    always_ff @(posedge tcb) begin
        if (gpio_vld && !wen) begin
            rdt <= rd_val;
        end
    end

    // output register only moves on a bus write
    a_out_hold : assert property (@(posedge tcb) disable iff (reset)
        !wr |=> $stable(out_val));

endmodule : gpio_regs

//--- src/gpio_io.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module gpio_io (
    input  logic               tcb,
    input  logic               reset,
    input  logic [`GPIO_W-1:0] gpio_i,
    input  logic [`GPIO_W-1:0] out_val,
    input  logic [`GPIO_W-1:0] oe_val,
    output logic [`GPIO_W-1:0] in_sync,
    output logic [`GPIO_W-1:0] rise_evt,
    output logic [`GPIO_W-1:0] gpio_o,
    output logic [`GPIO_W-1:0] gpio_e
);

    // two synchronizer stages and the previous synchronized sample
    logic [`GPIO_W-1:0] sync_0;
    logic [`GPIO_W-1:0] sync_1;
    logic [`GPIO_W-1:0] sync_prev;

    always_ff @(posedge tcb) begin
        if (reset) begin
            sync_0    <= '0;
            sync_1    <= '0;
            sync_prev <= '0;
        end else begin
            sync_0    <= gpio_i;
            sync_1    <= sync_0;
            sync_prev <= sync_1;
        end
    end

    assign in_sync  = sync_1;
    // low to high since the last sample
    assign rise_evt = sync_1 & ~sync_prev;

    // pad drive straight from the registers
    assign gpio_o = out_val;
    assign gpio_e = oe_val;

endmodule : gpio_io

//--- src/tcb_lite_soc.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module tcb_lite_soc (
    input  logic                   tcb,
    input  logic                   reset,
    // manager transfer
    input  logic                   vld,
    input  logic                   wen,
    input  logic [`TCB_ADR_W-1:0]  adr,
    input  tcb_lite_pkg::tcb_ben_t ben,
    input  logic [`TCB_DAT_W-1:0]  wdt,
    output logic [`TCB_DAT_W-1:0]  rdt,
    output logic                   err,
    // pins and status
    input  logic [`GPIO_W-1:0]     gpio_i,
    output logic [`GPIO_W-1:0]     gpio_o,
    output logic [`GPIO_W-1:0]     gpio_e,
    output logic                   irq,
    output logic                   bus_fault,
    output logic [`TCB_ADR_W-1:0]  fault_adr
);

    ////////////////////////////////////////
    // interconnect wires
    ////////////////////////////////////////

    // per subordinate strobes
    logic                  mem_vld;
    logic                  gpio_vld;
    logic                  err_vld;
    // per subordinate responses
    logic [`TCB_DAT_W-1:0] mem_rdt;
    logic [`TCB_DAT_W-1:0] gpio_rdt;
    logic [`TCB_DAT_W-1:0] sub_err_rdt;
    logic                  sub_err_err;
    // register block to pin logic
    logic [`GPIO_W-1:0]    out_val;
    logic [`GPIO_W-1:0]    oe_val;
    logic [`GPIO_W-1:0]    in_sync;
    logic [`GPIO_W-1:0]    rise_evt;

    tcb_lite_dec u_dec (
        .tcb         (tcb),
        .reset       (reset),
        .vld         (vld),
        .adr         (adr),
        .rdt         (rdt),
        .err         (err),
        .mem_vld     (mem_vld),
        .gpio_vld    (gpio_vld),
        .err_vld     (err_vld),
        .mem_rdt     (mem_rdt),
        .gpio_rdt    (gpio_rdt),
        .sub_err_rdt (sub_err_rdt),
        .sub_err_err (sub_err_err)
    );

    tcb_lite_sub_mem u_mem (
        .tcb     (tcb),
        .mem_vld (mem_vld),
        .wen     (wen),
        .adr     (adr),
        .ben     (ben),
        .wdt     (wdt),
        .rdt     (mem_rdt)
    );

    // catches everything outside the address map
    tcb_lite_sub_err u_err (
        .tcb       (tcb),
        .reset     (reset),
        .err_vld   (err_vld),
        .adr       (adr),
        .rdt       (sub_err_rdt),
        .err       (sub_err_err),
        .bus_fault (bus_fault),
        .fault_adr (fault_adr)
    );

    // interrupt enable stays inside the register block
    gpio_regs u_gpio_regs (
        .tcb      (tcb),
        .reset    (reset),
        .gpio_vld (gpio_vld),
        .wen      (wen),
        .adr      (adr),
        .wdt      (wdt),
        .rdt      (gpio_rdt),
        .out_val  (out_val),
        .oe_val   (oe_val),
        .irq_ena  (),
        .in_sync  (in_sync),
        .rise_evt (rise_evt),
        .irq      (irq)
    );

    gpio_io u_gpio_io (
        .tcb      (tcb),
        .reset    (reset),
        .gpio_i   (gpio_i),
        .out_val  (out_val),
        .oe_val   (oe_val),
        .in_sync  (in_sync),
        .rise_evt (rise_evt),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e)
    );

endmodule : tcb_lite_soc

//--- verification/tcb_lite_soc_tb.sv
`timescale 1ns/1ps

`include "tcb_lite_macros.svh"

module tcb_lite_soc_tb;

    import tcb_lite_pkg::*;
    import gpio_pkg::*;

    // upper bound on polls in every wait loop
    localparam int WAIT_MAX = 20;

    logic                  tcb;
    logic                  reset;
    logic                  vld;
    logic                  wen;
    logic [`TCB_ADR_W-1:0] adr;
    tcb_ben_t              ben;
    logic [`TCB_DAT_W-1:0] wdt;
    logic [`TCB_DAT_W-1:0] rdt;
    logic                  err;
    logic [`GPIO_W-1:0]    gpio_i;
    logic [`GPIO_W-1:0]    gpio_o;
    logic [`GPIO_W-1:0]    gpio_e;
    logic                  irq;
    logic                  bus_fault;
    logic [`TCB_ADR_W-1:0] fault_adr;

    // one bus transfer and its expected response
    typedef struct packed {
        logic                  wen;
        logic [`TCB_ADR_W-1:0] adr;
        tcb_ben_t              ben;
        logic [`TCB_DAT_W-1:0] wdt;
        logic [`GPIO_W-1:0]    gpio_i;
        logic [`TCB_DAT_W-1:0] exp_rdt;
        logic                  chk_rdt;
        logic                  exp_err;
    } row_t;

    row_t                  rows[$];
    // reference memory, 256 words
    logic [`TCB_DAT_W-1:0] ref_mem [0:255];
    // expected pin registers
    logic [`GPIO_W-1:0]    ref_out;
    logic [`GPIO_W-1:0]    ref_oe;
    // gpio_i value carried by rows as they are added
    logic [`GPIO_W-1:0]    cur_gpio_i;
    integer                seed;
    int                    checks;
    int                    errors;
    int                    timeouts;

    tcb_lite_soc uut (
        .tcb       (tcb),
        .reset     (reset),
        .vld       (vld),
        .wen       (wen),
        .adr       (adr),
        .ben       (ben),
        .wdt       (wdt),
        .rdt       (rdt),
        .err       (err),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_e    (gpio_e),
        .irq       (irq),
        .bus_fault (bus_fault),
        .fault_adr (fault_adr)
    );

    // 10 ns clock
    initial begin
        tcb = 1'b0;
        forever begin
            #5 tcb = ~tcb;
        end
    end

    ////////////////////////////////////////
    // address helpers
    ////////////////////////////////////////

    // lower 1 KiB of the memory region aliases upward
    function automatic logic [`MEM_ADR_W-3:0] word_idx(input logic [`TCB_ADR_W-1:0] a);
        return a[`MEM_ADR_W-1:2];
    endfunction

    function automatic logic [`TCB_ADR_W-1:0] gpio_adr(input gpio_reg_e r);
        return `GPIO_BASE + {{(`TCB_ADR_W-`GPIO_REGION_W){1'b0}}, r};
    endfunction

    // pin value widened to a bus word
    function automatic logic [`TCB_DAT_W-1:0] pad_word(input logic [`GPIO_W-1:0] v);
        return {{(`TCB_DAT_W-`GPIO_W){1'b0}}, v};
    endfunction

    ////////////////////////////////////////
    // table construction
    ////////////////////////////////////////

    task automatic add_row(input logic w, input logic [`TCB_ADR_W-1:0] a, input tcb_ben_t b,
                           input logic [`TCB_DAT_W-1:0] d, input logic [`TCB_DAT_W-1:0] exp,
                           input logic chk, input logic e);
        row_t r;
        r.wen     = w;
        r.adr     = a;
        r.ben     = b;
        r.wdt     = d;
        r.gpio_i  = cur_gpio_i;
        r.exp_rdt = exp;
        r.chk_rdt = chk;
        r.exp_err = e;
        rows.push_back(r);
    endtask

    // merge enabled bytes into the reference word
    task automatic mem_write(input logic [`TCB_ADR_W-1:0] a, input tcb_ben_t b,
                             input logic [`TCB_DAT_W-1:0] d);
        int k;
        for (k = 0; k < `TCB_BEN_W; k++) begin
            if (b[k]) begin
                ref_mem[word_idx(a)][8*k +: 8] = d[8*k +: 8];
            end
        end
        add_row(1'b1, a, b, d, '0, 1'b0, 1'b0);
    endtask

    task automatic mem_read(input logic [`TCB_ADR_W-1:0] a);
        add_row(1'b0, a, '0, '0, ref_mem[word_idx(a)], 1'b1, 1'b0);
    endtask

    // set mask in the upper half wins over clear mask in the lower half
    task automatic gpio_write(input gpio_reg_e r, input logic [`TCB_DAT_W-1:0] d);
        case (r)
            REG_OUT:    ref_out = d[`GPIO_W-1:0];
            REG_SETCLR: ref_out = (ref_out & ~d[`GPIO_W-1:0]) | d[`TCB_DAT_W-1:`GPIO_W];
            REG_OE:     ref_oe  = d[`GPIO_W-1:0];
            default: ;
        endcase
        add_row(1'b1, gpio_adr(r), 4'hf, d, '0, 1'b0, 1'b0);
    endtask

    // REG_IN rows need two rows of distance from the last gpio_i change
    task automatic gpio_read(input gpio_reg_e r);
        logic [`GPIO_W-1:0] exp;
        case (r)
            REG_OUT: exp = ref_out;
            REG_OE:  exp = ref_oe;
            REG_IN:  exp = cur_gpio_i;
            // setclr is write only
            default: exp = '0;
        endcase
        add_row(1'b0, gpio_adr(r), '0, '0, pad_word(exp), 1'b1, 1'b0);
    endtask

    // unmapped access answers err with zero data
    task automatic bad_access(input logic w, input logic [`TCB_ADR_W-1:0] a);
        add_row(w, a, 4'hf, 32'h1234_5678, '0, 1'b1, 1'b1);
    endtask

    task automatic build_directed_table();
        rows.delete();
        cur_gpio_i = '0;
        // full words first, then partial merges read straight back
        mem_write(32'h0000_0010, 4'hf, 32'h1122_3344);
        mem_write(32'h0000_0014, 4'hf, 32'hdead_beef);
        mem_write(32'h0000_0010, 4'b0101, 32'haabb_ccdd);
        mem_read(32'h0000_0010);
        mem_write(32'h0000_0014, 4'b1000, 32'h5500_0000);
        mem_read(32'h0000_0014);
        // alias of word 0x10
        mem_read(32'h0000_0410);
        // regions interleaved back to back
        bad_access(1'b0, 32'h0002_0000);
        gpio_write(REG_OUT, 32'h0000_f00f);
        bad_access(1'b1, 32'h8000_0004);
        mem_read(32'h0000_0014);
        // bit 0 both set and cleared
        gpio_write(REG_SETCLR, 32'h0303_0f01);
        gpio_read(REG_OUT);
        gpio_write(REG_OE, 32'h0000_00ff);
        cur_gpio_i = 16'h00a5;
        gpio_read(REG_OE);
        // first address past the gpio region
        bad_access(1'b0, 32'h0001_0100);
        gpio_read(REG_SETCLR);
        gpio_read(REG_IN);
        mem_read(32'h0000_0010);
    endtask

    task automatic build_random_table();
        logic [`TCB_DAT_W-1:0] rnd;
        logic [`TCB_ADR_W-1:0] a;
        tcb_ben_t              b;
        int                    k;
        rows.delete();
        for (k = 0; k < 16; k++) begin
            a   = 32'h0000_0100 + 4 * k;
            rnd = $random(seed);
            mem_write(a, 4'hf, rnd);
            rnd = $random(seed);
            b   = rnd[`TCB_BEN_W-1:0];
            // a write needs one enabled byte at least
            if (b == '0) begin
                b = 4'b0010;
            end
            rnd = $random(seed);
            mem_write(a, b, rnd);
        end
        for (k = 0; k < 16; k++) begin
            mem_read(32'h0000_0100 + 4 * k);
        end
    endtask

    ////////////////////////////////////////
    // table execution
    ////////////////////////////////////////

    task automatic check_row(input row_t r);
        checks++;
        assert (err === r.exp_err) else begin
            errors++;
            $display("[ERROR] %0t: adr %h err %b, expected %b", $time, r.adr, err, r.exp_err);
        end
        assert (bus_fault === r.exp_err) else begin
            errors++;
            $display("[ERROR] %0t: adr %h bus_fault %b, expected %b",
                     $time, r.adr, bus_fault, r.exp_err);
        end
        if (r.chk_rdt) begin
            assert (rdt === r.exp_rdt) else begin
                errors++;
                $display("[ERROR] %0t: adr %h rdt %h, expected %h",
                         $time, r.adr, rdt, r.exp_rdt);
            end
        end
        if (r.exp_err) begin
            assert (fault_adr === r.adr) else begin
                errors++;
                $display("[ERROR] %0t: fault_adr %h, expected %h", $time, fault_adr, r.adr);
            end
        end
    endtask

    // one row per cycle, response checked mid-cycle after acceptance
    task automatic run_table();
        int i;
        for (i = 0; i <= rows.size(); i++) begin
            @(posedge tcb);
            if (i < rows.size()) begin
                vld    <= 1'b1;
                wen    <= rows[i].wen;
                adr    <= rows[i].adr;
                ben    <= rows[i].ben;
                wdt    <= rows[i].wdt;
                gpio_i <= rows[i].gpio_i;
            end else begin
                vld <= 1'b0;
            end
            @(negedge tcb);
            if (i > 0) begin
                check_row(rows[i-1]);
            end
        end
    endtask

    ////////////////////////////////////////
    // single transfers and waits
    ////////////////////////////////////////

    // response lands one clock after acceptance
    // only gpio registers are reached here so err stays low
    task automatic bus_xfer(input logic w, input logic [`TCB_ADR_W-1:0] a,
                            input logic [`TCB_DAT_W-1:0] d,
                            output logic [`TCB_DAT_W-1:0] r);
        @(posedge tcb);
        vld <= 1'b1;
        wen <= w;
        adr <= a;
        ben <= 4'hf;
        wdt <= d;
        @(posedge tcb);
        vld <= 1'b0;
        @(negedge tcb);
        r = rdt;
        checks++;
        assert (err === 1'b0) else begin
            errors++;
            $display("[ERROR] %0t: adr %h err %b, expected 0", $time, a, err);
        end
    endtask

    task automatic wait_reg(input gpio_reg_e r, input logic [`GPIO_W-1:0] exp);
        logic [`TCB_DAT_W-1:0] rd;
        int                    n;
        n = 0;
        bus_xfer(1'b0, gpio_adr(r), '0, rd);
        while (rd !== pad_word(exp) && n < WAIT_MAX) begin
            bus_xfer(1'b0, gpio_adr(r), '0, rd);
            n++;
        end
        checks++;
        assert (rd === pad_word(exp)) else begin
            timeouts++;
            $display("timeout at %0t: %s never read back as %h", $time, r.name(), exp);
        end
    endtask

    task automatic wait_pins(input logic [`GPIO_W-1:0] o, input logic [`GPIO_W-1:0] oe);
        int n;
        n = 0;
        while ((gpio_o !== o || gpio_e !== oe) && n < WAIT_MAX) begin
            @(negedge tcb);
            n++;
        end
        checks++;
        assert (gpio_o === o && gpio_e === oe) else begin
            timeouts++;
            $display("timeout at %0t: pins show out %h oe %h instead of out %h oe %h",
                     $time, gpio_o, gpio_e, o, oe);
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level && n < WAIT_MAX) begin
            @(negedge tcb);
            n++;
        end
        checks++;
        assert (irq === level) else begin
            timeouts++;
            $display("timeout at %0t: irq never went to %b", $time, level);
        end
    endtask

    task automatic expect_irq_low(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge tcb);
            checks++;
            assert (irq === 1'b0) else begin
                errors++;
                $display("[ERROR] %0t: irq high with no enabled pending bit", $time);
            end
        end
    endtask

    task automatic check_reset_values();
        @(negedge tcb);
        checks++;
        assert (rdt === '0 && err === 1'b0 && bus_fault === 1'b0 && irq === 1'b0 &&
                gpio_o === '0 && gpio_e === '0 && fault_adr === '0) else begin
            errors++;
            $display("[ERROR] %0t: outputs not zero after reset", $time);
        end
    endtask

    ////////////////////////////////////////
    // input sync and interrupt
    ////////////////////////////////////////

    task automatic run_irq_phase();
        logic [`TCB_DAT_W-1:0] rd;
        logic [`GPIO_W-1:0]    old_in;
        logic [`GPIO_W-1:0]    new_in;
        logic [`GPIO_W-1:0]    pnd;
        logic [`GPIO_W-1:0]    hit;
        // drop events left over from the table
        bus_xfer(1'b1, gpio_adr(REG_IRQ_PND), pad_word('1), rd);
        wait_reg(REG_IRQ_PND, '0);
        old_in = gpio_i;
        new_in = 16'h5aff;
        // only low to high bits become pending
        pnd    = new_in & ~old_in;
        @(posedge tcb);
        gpio_i <= new_in;
        wait_reg(REG_IN, new_in);
        wait_reg(REG_IRQ_PND, pnd);
        // enable covers nothing pending
        bus_xfer(1'b1, gpio_adr(REG_IRQ_ENA), pad_word(~pnd), rd);
        expect_irq_low(4);
        hit = pnd & 16'h0202;
        bus_xfer(1'b1, gpio_adr(REG_IRQ_ENA), pad_word(hit), rd);
        wait_irq(1'b1);
        // write one to clear the enabled bits only
        bus_xfer(1'b1, gpio_adr(REG_IRQ_PND), pad_word(hit), rd);
        wait_irq(1'b0);
        wait_reg(REG_IRQ_PND, pnd & ~hit);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : main
        vld        = 1'b0;
        wen        = 1'b0;
        adr        = '0;
        ben        = '0;
        wdt        = '0;
        gpio_i     = '0;
        reset      = 1'b1;
        seed       = 32'hb8581a06;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        ref_out    = '0;
        ref_oe     = '0;
        cur_gpio_i = '0;
        repeat (16) @(posedge tcb);
        reset <= 1'b0;
        check_reset_values();
        build_directed_table();
        run_table();
        wait_pins(ref_out, ref_oe);
        build_random_table();
        run_table();
        run_irq_phase();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tcb_lite_soc_tb

//--- sources.f
+incdir+src
src/tcb_lite_pkg.sv
src/gpio_pkg.sv
src/tcb_lite_dec.sv
src/tcb_lite_sub_mem.sv
src/tcb_lite_sub_err.sv
src/gpio_regs.sv
src/gpio_io.sv
src/tcb_lite_soc.sv
verification/tcb_lite_soc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tcb_lite_soc_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --assert -j 0
LFLAGS    ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message missing from $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
